/* Bender.yml */
package:
  name: sha3_pad

sources:
  - sha3_pad_pkg.sv
  - pad_block_counter.sv
  - pad_prefix_gen.sv
  - pad_suffix_gen.sv
  - pad_fsm.sv
  - pad_output_mux.sv
  - sha3_pad.sv
  - target: test
    files:
      - tb_sha3_pad.sv

/* pad_block_counter.sv */
// Word counter for the current keccak block. It also derives the block limit
// from the strength and flags the last word and the full block.

`timescale 1ns/1ns

module pad_block_counter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  sha3_pad_pkg::keccak_strength_e   strength_i,
  input  logic                             clr_i,
  input  logic                             incr_i,
  output sha3_pad_pkg::keccak_addr_t       word_addr_o,
  output logic                             sent_blocksize_o,
  output logic                             end_of_block_o
);
  import sha3_pad_pkg::*;

  logic [KeccakCountW-1:0] block_limit;
  logic [KeccakCountW-1:0] sent_count;

  // number of words in one block for the selected strength
  always_comb begin
    unique case (strength_i)
      L128:    block_limit = KeccakCountW'(KeccakRateWords[L128]);
      L224:    block_limit = KeccakCountW'(KeccakRateWords[L224]);
      L256:    block_limit = KeccakCountW'(KeccakRateWords[L256]);
      L384:    block_limit = KeccakCountW'(KeccakRateWords[L384]);
      L512:    block_limit = KeccakCountW'(KeccakRateWords[L512]);
      default: block_limit = '0;
    endcase
  end

  // clear wins over increment, the FSM clears on the cycle it starts a run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_count <= '0;
    end else if (clr_i) begin
      sent_count <= '0;
    end else if (incr_i) begin
      sent_count <= sent_count + KeccakCountW'(1);
    end
  end

  // address wraps to 0 once the block is complete
  assign word_addr_o      = (sent_count < block_limit) ? sent_count : '0;
  assign sent_blocksize_o = (sent_count == block_limit);
  // the word currently offered is the last one of the block
  assign end_of_block_o   = ((sent_count + KeccakCountW'(1)) == block_limit);

endmodule

/* pad_fsm.sv */
// Padding state machine. Steps through prefix, message, function pad and
// zero fill, starts the keccak rounds per block and reports absorbed.
// A latched process request is held until done_i.

`timescale 1ns/1ns

module pad_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  sha3_pad_pkg::sha3_mode_e    mode_i,
  input  logic                        start_i,
  input  logic                        process_i,
  input  logic                        done_i,
  input  logic                        msg_valid_i,
  input  sha3_pad_pkg::msg_strb_t     msg_strb_i,
  input  logic                        keccak_ack_i,
  input  logic                        keccak_complete_i,
  input  logic                        sent_blocksize_i,
  input  logic                        end_of_block_i,
  output sha3_pad_pkg::mux_sel_e      sel_mux_o,
  output logic                        fsm_valid_o,
  output logic                        hold_msg_o,
  output logic                        en_msgbuf_o,
  output logic                        clr_msgbuf_o,
  output logic                        clr_count_o,
  output logic                        keccak_run_o,
  output logic                        absorbed_o
);
  import sha3_pad_pkg::*;

  typedef enum logic [3:0] {
    StPadIdle,
    StPrefix,
    StPrefixWait,
    StMessage,
    StMessageWait,
    StPad,
    StPadRun,
    StPad01,
    StPadFlush
  } pad_st_e;

  pad_st_e st, st_d;
  logic    process_latched;
  logic    absorbed_d;
  logic    msg_partial;

  // only the last word of a message may miss strobes
  assign msg_partial = ~(&msg_strb_i);

  // process may arrive while the prefix is still going out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_latched <= 1'b0;
    end else if (process_i) begin
      process_latched <= 1'b1;
    end else if (done_i) begin
      process_latched <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st         <= StPadIdle;
      absorbed_o <= 1'b0;
    end else begin
      st         <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d         = st;
    sel_mux_o    = MuxNone;
    fsm_valid_o  = 1'b0;
    hold_msg_o   = 1'b0;
    en_msgbuf_o  = 1'b0;
    clr_msgbuf_o = 1'b0;
    clr_count_o  = 1'b0;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;

    unique case (st)
      StPadIdle: begin
        // cSHAKE sends a whole prefix block before any message
        if (start_i) begin
          st_d = (mode_i == CShake) ? StPrefix : StMessage;
        end
      end

      StPrefix: begin
        sel_mux_o = MuxPrefix;
        if (sent_blocksize_i) begin
          st_d         = StPrefixWait;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      StPrefixWait: begin
        sel_mux_o = MuxPrefix;
        if (keccak_complete_i) begin
          st_d = StMessage;
        end
      end

      StMessage: begin
        sel_mux_o = MuxFifo;
        if (msg_valid_i && msg_partial) begin
          // take the tail word into the buffer, it goes out with the pad
          en_msgbuf_o = 1'b1;
        end else if (sent_blocksize_i) begin
          // a full block wins over a pending process request
          st_d         = StMessageWait;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
          hold_msg_o   = 1'b1;
        end else if (process_latched || process_i) begin
          st_d       = StPad;
          hold_msg_o = 1'b1;
        end
      end

      StMessageWait: begin
        hold_msg_o = 1'b1;
        if (keccak_complete_i) begin
          st_d = StMessage;
        end
      end

      StPad: begin
        sel_mux_o   = MuxFuncPad;
        fsm_valid_o = 1'b1;
        if (keccak_ack_i && end_of_block_i) begin
          // the pad word already carries the final bit
          st_d         = StPadRun;
          clr_msgbuf_o = 1'b1;
          clr_count_o  = 1'b1;
        end else if (keccak_ack_i) begin
          st_d         = StPad01;
          clr_msgbuf_o = 1'b1;
        end
      end

      StPadRun: begin
        st_d         = StPadFlush;
        keccak_run_o = 1'b1;
        clr_count_o  = 1'b1;
      end

      StPad01: begin
        // zero fill until the block is full, the last word gets bit 63
        sel_mux_o = MuxZeroEnd;
        if (sent_blocksize_i) begin
          st_d         = StPadFlush;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      StPadFlush: begin
        clr_count_o  = 1'b1;
        clr_msgbuf_o = 1'b1;
        if (keccak_complete_i) begin
          st_d       = StPadIdle;
          absorbed_d = 1'b1;
        end
      end

      default: begin
        st_d = StPadIdle;
      end
    endcase
  end

endmodule

/* pad_output_mux.sv */
// Output steering toward the keccak state. Picks data and valid from the
// active source, drives the message ready and flags accepted words.

`timescale 1ns/1ns

module pad_output_mux (
  input  sha3_pad_pkg::mux_sel_e  sel_mux_i,
  input  logic                    fsm_valid_i,
  input  logic                    hold_msg_i,
  input  logic                    en_msgbuf_i,
  input  logic                    msg_valid_i,
  input  sha3_pad_pkg::msg_data_t msg_data_i,
  input  sha3_pad_pkg::msg_data_t prefix_word_i,
  input  sha3_pad_pkg::msg_data_t funcpad_word_i,
  input  sha3_pad_pkg::msg_data_t zero_end_word_i,
  input  logic                    keccak_ready_i,
  output logic                    keccak_valid_o,
  output sha3_pad_pkg::msg_data_t keccak_data_o,
  output logic                    msg_ready_o,
  output logic                    keccak_ack_o
);
  import sha3_pad_pkg::*;

  always_comb begin
    keccak_data_o  = '0;
    keccak_valid_o = 1'b0;
    msg_ready_o    = 1'b0;
    unique case (sel_mux_i)
      MuxFifo: begin
        keccak_data_o  = msg_data_i;
        // a buffered partial word is never forwarded
        keccak_valid_o = msg_valid_i & ~hold_msg_i & ~en_msgbuf_i;
        // buffering accepts the word without waiting on the keccak side
        msg_ready_o    = en_msgbuf_i | (keccak_ready_i & ~hold_msg_i);
      end
      MuxPrefix: begin
        keccak_data_o  = prefix_word_i;
        keccak_valid_o = fsm_valid_i;
      end
      MuxFuncPad: begin
        keccak_data_o  = funcpad_word_i;
        keccak_valid_o = fsm_valid_i;
      end
      MuxZeroEnd: begin
        keccak_data_o  = zero_end_word_i;
        keccak_valid_o = fsm_valid_i;
      end
      default: begin
        keccak_data_o = '0;
      end
    endcase
  end

  // counts toward the block on every word the keccak side takes
  assign keccak_ack_o = keccak_valid_o & keccak_ready_i;

endmodule

/* pad_prefix_gen.sv */
// cSHAKE prefix source. Builds bytepad(encode_string(N) || encode_string(S))
// from the software N/S string and returns the 64-bit word at the address.

`timescale 1ns/1ns

module pad_prefix_gen (
  input  sha3_pad_pkg::keccak_strength_e strength_i,
  input  sha3_pad_pkg::ns_data_t         ns_data_i,
  input  sha3_pad_pkg::keccak_addr_t     word_addr_i,
  output sha3_pad_pkg::msg_data_t        prefix_word_o
);
  import sha3_pad_pkg::*;

  logic [7:0] rate_byte;
  prefix_t    prefix;

  // left_encode(rate in bytes) is the byte 8'h01 followed by the rate
  // only the cSHAKE strengths have a defined rate byte
  always_comb begin
    unique case (strength_i)
      L128:    rate_byte = 8'd168;
      L256:    rate_byte = 8'd136;
      default: rate_byte = 8'd0;
    endcase
  end

  // byte 0 goes out first, N/S follows right after the two encoding bytes
  assign prefix = {ns_data_i, rate_byte, 8'h01};

  // past the prefix the rest of the block is zero fill
  always_comb begin
    if (int'(word_addr_i) < (PrefixBytes / 8)) begin
      prefix_word_o = prefix[int'(word_addr_i)*MsgWidth +: MsgWidth];
    end else begin
      prefix_word_o = '0;
    end
  end

endmodule

/* pad_suffix_gen.sv */
// Function pad source. Keeps the partial last message word and merges it
// with the mode suffix and the first bit of pad10*1. Also forms the zero
// fill word that closes the block.

`timescale 1ns/1ns

module pad_suffix_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  sha3_pad_pkg::sha3_mode_e    mode_i,
  input  sha3_pad_pkg::msg_data_t     msg_data_i,
  input  sha3_pad_pkg::msg_strb_t     msg_strb_i,
  input  logic                        en_msgbuf_i,
  input  logic                        clr_msgbuf_i,
  input  logic                        end_of_block_i,
  output sha3_pad_pkg::msg_data_t     funcpad_word_o,
  output sha3_pad_pkg::msg_data_t     zero_end_word_o
);
  import sha3_pad_pkg::*;

  // a partial word never strobes byte 7, so seven bytes are enough
  logic [MsgWidth-8-1:0] msg_buf;
  logic [MsgStrbW-2:0]   msg_strb;
  logic [4:0]            funcpad;

  // mode suffix with the leading 1 of pad10*1 already appended
  // SHA3 adds 01, SHAKE adds 1111 and cSHAKE adds 00
  always_comb begin
    unique case (mode_i)
      Sha3:    funcpad = 5'b00110;
      Shake:   funcpad = 5'b11111;
      CShake:  funcpad = 5'b00100;
      default: funcpad = 5'b00001;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (en_msgbuf_i) begin
      msg_buf <= msg_data_i[MsgWidth-8-1:0];
    end
  end

  // the strobes decide how many buffered bytes take part in the pad word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msg_strb <= '0;
    end else if (en_msgbuf_i) begin
      msg_strb <= msg_strb_i[MsgStrbW-2:0];
    end else if (clr_msgbuf_i) begin
      msg_strb <= '0;
    end
  end

  // suffix lands in the byte right after the last buffered one
  // bit 63 closes pad10*1 when this word is the last of the block
  always_comb begin
    unique case (msg_strb)
      7'b000_0000: funcpad_word_o = {end_of_block_i, 63'(funcpad)};
      7'b000_0001: funcpad_word_o = {end_of_block_i, 55'(funcpad), msg_buf[7:0]};
      7'b000_0011: funcpad_word_o = {end_of_block_i, 47'(funcpad), msg_buf[15:0]};
      7'b000_0111: funcpad_word_o = {end_of_block_i, 39'(funcpad), msg_buf[23:0]};
      7'b000_1111: funcpad_word_o = {end_of_block_i, 31'(funcpad), msg_buf[31:0]};
      7'b001_1111: funcpad_word_o = {end_of_block_i, 23'(funcpad), msg_buf[39:0]};
      7'b011_1111: funcpad_word_o = {end_of_block_i, 15'(funcpad), msg_buf[47:0]};
      7'b111_1111: funcpad_word_o = {end_of_block_i, 7'(funcpad), msg_buf[55:0]};
      default:     funcpad_word_o = '0;
    endcase
  end

  // zero fill, with the final pad bit on the last word of the block
  assign zero_end_word_o = {end_of_block_i, {(MsgWidth-1){1'b0}}};

endmodule

/* sha3_pad.f */
sha3_pad_pkg.sv
pad_block_counter.sv
pad_prefix_gen.sv
pad_suffix_gen.sv
pad_fsm.sv
pad_output_mux.sv
sha3_pad.sv
tb_sha3_pad.sv

/* sha3_pad.sv */
// SHA3 sponge padding unit, top level. Sits between the message FIFO and
// the keccak round engine and supports SHA3, SHAKE and cSHAKE.

`timescale 1ns/1ns

module sha3_pad (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // message FIFO side
  input  logic                             msg_valid_i,
  input  sha3_pad_pkg::msg_data_t          msg_data_i,
  input  sha3_pad_pkg::msg_strb_t          msg_strb_i,
  output logic                             msg_ready_o,

  // N/S string for cSHAKE, prepared by software
  input  sha3_pad_pkg::ns_data_t           ns_data_i,

  // keccak state write port
  output logic                             keccak_valid_o,
  output sha3_pad_pkg::keccak_addr_t       keccak_addr_o,
  output sha3_pad_pkg::msg_data_t          keccak_data_o,
  input  logic                             keccak_ready_i,

  // keccak round control
  output logic                             keccak_run_o,
  input  logic                             keccak_complete_i,

  // configuration, stable from start until absorbed
  input  sha3_pad_pkg::sha3_mode_e         mode_i,
  input  sha3_pad_pkg::keccak_strength_e   strength_i,

  // control pulses
  input  logic                             start_i,
  input  logic                             process_i,
  input  logic                             done_i,
  output logic                             absorbed_o
);
  import sha3_pad_pkg::*;

  mux_sel_e  sel_mux;
  logic      fsm_valid;
  logic      hold_msg;
  logic      en_msgbuf;
  logic      clr_msgbuf;
  logic      clr_count;
  logic      keccak_ack;
  logic      sent_blocksize;
  logic      end_of_block;
  msg_data_t prefix_word;
  msg_data_t funcpad_word;
  msg_data_t zero_end_word;

  // the counter address feeds both the prefix slicer and the state port
  pad_block_counter u_block_counter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .strength_i       (strength_i),
    .clr_i            (clr_count),
    .incr_i           (keccak_ack),
    .word_addr_o      (keccak_addr_o),
    .sent_blocksize_o (sent_blocksize),
    .end_of_block_o   (end_of_block)
  );

  pad_prefix_gen u_prefix_gen (
    .strength_i    (strength_i),
    .ns_data_i     (ns_data_i),
    .word_addr_i   (keccak_addr_o),
    .prefix_word_o (prefix_word)
  );

  pad_suffix_gen u_suffix_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mode_i          (mode_i),
    .msg_data_i      (msg_data_i),
    .msg_strb_i      (msg_strb_i),
    .en_msgbuf_i     (en_msgbuf),
    .clr_msgbuf_i    (clr_msgbuf),
    .end_of_block_i  (end_of_block),
    .funcpad_word_o  (funcpad_word),
    .zero_end_word_o (zero_end_word)
  );

  pad_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .mode_i            (mode_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .done_i            (done_i),
    .msg_valid_i       (msg_valid_i),
    .msg_strb_i        (msg_strb_i),
    .keccak_ack_i      (keccak_ack),
    .keccak_complete_i (keccak_complete_i),
    .sent_blocksize_i  (sent_blocksize),
    .end_of_block_i    (end_of_block),
    .sel_mux_o         (sel_mux),
    .fsm_valid_o       (fsm_valid),
    .hold_msg_o        (hold_msg),
    .en_msgbuf_o       (en_msgbuf),
    .clr_msgbuf_o      (clr_msgbuf),
    .clr_count_o       (clr_count),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o)
  );

  pad_output_mux u_output_mux (
    .sel_mux_i       (sel_mux),
    .fsm_valid_i     (fsm_valid),
    .hold_msg_i      (hold_msg),
    .en_msgbuf_i     (en_msgbuf),
    .msg_valid_i     (msg_valid_i),
    .msg_data_i      (msg_data_i),
    .prefix_word_i   (prefix_word),
    .funcpad_word_i  (funcpad_word),
    .zero_end_word_i (zero_end_word),
    .keccak_ready_i  (keccak_ready_i),
    .keccak_valid_o  (keccak_valid_o),
    .keccak_data_o   (keccak_data_o),
    .msg_ready_o     (msg_ready_o),
    .keccak_ack_o    (keccak_ack)
  );

endmodule

/* sha3_pad_pkg.sv */
// Shared widths, block rates, mode encodings and data types for the SHA3
// sponge padding unit. Every RTL block pulls its types from here.

package sha3_pad_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // one message word as it is written into the keccak state
  localparam int MsgWidth = 64;
  localparam int MsgStrbW = MsgWidth / 8;

  // word counter inside a block, covers all 25 lanes of the state
  localparam int KeccakCountW = 5;

  // encode_string(N) || encode_string(S) as prepared by software
  localparam int NsBytes = 30;

  // the two bytepad bytes sit in front of the N/S string
  // the whole prefix stays below the smallest rate (72 bytes for L512)
  localparam int PrefixBytes = NsBytes + 2;

  ////////////////////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [MsgWidth-1:0]      msg_data_t;
  typedef logic [MsgStrbW-1:0]      msg_strb_t;
  typedef logic [KeccakCountW-1:0]  keccak_addr_t;
  typedef logic [NsBytes*8-1:0]     ns_data_t;
  typedef logic [PrefixBytes*8-1:0] prefix_t;

  typedef enum logic [1:0] {
    Sha3   = 2'b00,
    Shake  = 2'b01,
    CShake = 2'b10
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'b000,
    L224 = 3'b001,
    L256 = 3'b010,
    L384 = 3'b011,
    L512 = 3'b100
  } keccak_strength_e;

  // source of the word that goes to the keccak state
  typedef enum logic [2:0] {
    MuxNone    = 3'b000,
    MuxFifo    = 3'b001,
    MuxPrefix  = 3'b010,
    MuxFuncPad = 3'b011,
    MuxZeroEnd = 3'b100
  } mux_sel_e;

  // block rate in 64-bit words, indexed by keccak_strength_e
  // that is (1600 - 2 * strength) / 64
  localparam int KeccakRateWords [5] = '{21, 18, 17, 13, 9};

endpackage

/* tb_sha3_pad.sv */
// Directed testbench for the SHA3 sponge padding unit. Drives messages for
// SHA3, SHAKE and cSHAKE through the top level, models the keccak engine and
// compares the recorded word stream with a reference padder.

`timescale 1ns/1ns

module tb_sha3_pad;
  import sha3_pad_pkg::*;

  localparam int StreamMax = 64;
  localparam int WaitLimit = 1000;
  localparam logic [31:0] Seed = 32'h5bc6417f;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             msg_valid_i;
  msg_data_t        msg_data_i;
  msg_strb_t        msg_strb_i;
  logic             msg_ready_o;
  ns_data_t         ns_data_i;
  logic             keccak_valid_o;
  keccak_addr_t     keccak_addr_o;
  msg_data_t        keccak_data_o;
  logic             keccak_ready_i = 1'b1;
  logic             keccak_run_o;
  logic             keccak_complete_i = 1'b0;
  sha3_mode_e       mode_i;
  keccak_strength_e strength_i;
  logic             start_i;
  logic             process_i;
  logic             done_i;
  logic             absorbed_o;

  // recorded stream, reference stream and the unstalled cSHAKE result
  msg_data_t    rec_data [StreamMax];
  keccak_addr_t rec_addr [StreamMax];
  msg_data_t    exp_data [StreamMax];
  keccak_addr_t exp_addr [StreamMax];
  msg_data_t    saved_data [StreamMax];
  keccak_addr_t saved_addr [StreamMax];
  int           rec_len = 0;
  int           exp_len = 0;
  int           saved_len = 0;
  int           saved_runs = 0;

  msg_data_t    msg_words [32];
  logic [255:0] ns_fill;
  logic [31:0]  rng = Seed;
  logic         stall_en = 1'b0;

  int run_count = 0;
  int absorbed_count = 0;
  int eng_count = 0;
  logic complete_seen = 1'b0;
  int err_value = 0;
  int err_proto = 0;
  int err_timeout = 0;

  always #20 clk_i = ~clk_i;

  sha3_pad dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .msg_valid_i       (msg_valid_i),
    .msg_data_i        (msg_data_i),
    .msg_strb_i        (msg_strb_i),
    .msg_ready_o       (msg_ready_o),
    .ns_data_i         (ns_data_i),
    .keccak_valid_o    (keccak_valid_o),
    .keccak_addr_o     (keccak_addr_o),
    .keccak_data_o     (keccak_data_o),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_run_o      (keccak_run_o),
    .keccak_complete_i (keccak_complete_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .done_i            (done_i),
    .absorbed_o        (absorbed_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // keccak engine model
  ////////////////////////////////////////////////////////////////////////////

  // all reads here see the values from before the edge
  always @(posedge clk_i) begin
    if (keccak_valid_o === 1'b1 && keccak_ready_i === 1'b1) begin
      if (rec_len < StreamMax) begin
        rec_data[rec_len] = keccak_data_o;
        rec_addr[rec_len] = keccak_addr_o;
        rec_len++;
      end else begin
        err_proto++;
        $display("more keccak words arrived than the recording holds at %0t ns", $time);
      end
    end
    // the message side has to wait while a block is being permuted
    if (msg_ready_o === 1'b1 && (eng_count > 0 || keccak_complete_i)) begin
      err_proto++;
      $display("msg_ready_o went high while the keccak engine was busy at %0t ns", $time);
    end
    if (absorbed_o === 1'b1) begin
      absorbed_count++;
      if (!complete_seen) begin
        err_proto++;
        $display("absorbed_o did not come one cycle after keccak_complete_i at %0t ns", $time);
      end
    end
    complete_seen = keccak_complete_i;
    // complete goes high six edges after the run pulse is seen
    if (eng_count > 0) begin
      keccak_complete_i <= (eng_count == 1);
      eng_count--;
    end else begin
      keccak_complete_i <= 1'b0;
    end
    if (keccak_run_o === 1'b1) begin
      run_count++;
      if (eng_count > 0 || keccak_complete_i) begin
        err_proto++;
        $display("unexpected keccak_run_o pulse while the engine was busy at %0t ns", $time);
      end
      eng_count = 6;
    end
  end

  // random back-pressure, only advances the generator while stalling
  always @(posedge clk_i) begin
    if (stall_en) begin
      rng = xorshift32(rng);
      keccak_ready_i <= rng[7];
    end else begin
      keccak_ready_i <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference padder
  ////////////////////////////////////////////////////////////////////////////

  function automatic int rate_words(keccak_strength_e s);
    case (s)
      L128:    return 21;
      L224:    return 18;
      L256:    return 17;
      L384:    return 13;
      default: return 9;
    endcase
  endfunction

  // mode suffix plus the leading 1 of pad10*1, as one byte
  function automatic logic [7:0] funcpad_byte(sha3_mode_e m);
    case (m)
      Sha3:    return 8'h06;
      Shake:   return 8'h1f;
      default: return 8'h04;
    endcase
  endfunction

  function automatic void push_expected(msg_data_t w, int rate);
    exp_data[exp_len] = w;
    exp_addr[exp_len] = keccak_addr_t'(exp_len % rate);
    exp_len++;
  endfunction

  function automatic void build_expected(sha3_mode_e m, keccak_strength_e s, int nfull,
                                         int nbytes);
    int        rate;
    int        i;
    int        b;
    int        k;
    logic [7:0] pb;
    msg_data_t w;
    rate = rate_words(s);
    exp_len = 0;
    // cSHAKE prefix block is bytepad of the two encoding bytes and N/S
    if (m == CShake) begin
      for (i = 0; i < rate; i++) begin
        w = '0;
        for (b = 0; b < 8; b++) begin
          k = 8 * i + b;
          if (k == 0) begin
            pb = 8'h01;
          end else if (k == 1) begin
            pb = (s == L128) ? 8'd168 : ((s == L256) ? 8'd136 : 8'd0);
          end else if (k < 32) begin
            pb = ns_data_i[8*(k-2) +: 8];
          end else begin
            pb = 8'h00;
          end
          w[8*b +: 8] = pb;
        end
        push_expected(w, rate);
      end
    end
    for (i = 0; i < nfull; i++) begin
      push_expected(msg_words[i], rate);
    end
    w = '0;
    for (b = 0; b < nbytes; b++) begin
      w[8*b +: 8] = msg_words[nfull][8*b +: 8];
    end
    w[8*nbytes +: 8] = funcpad_byte(m);
    if ((exp_len % rate) == rate - 1) begin
      w[63] = 1'b1;
    end
    push_expected(w, rate);
    // zero fill up to the end of the block, final pad bit on the last word
    while ((exp_len % rate) != 0) begin
      w = '0;
      w[63] = ((exp_len % rate) == rate - 1);
      push_expected(w, rate);
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(string what, msg_data_t got, msg_data_t exp);
    if (got !== exp) begin
      err_value++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(string what, keccak_addr_t got, keccak_addr_t exp);
    if (got !== exp) begin
      err_value++;
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      err_value++;
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_stream();
    int i;
    check_count("stream length", rec_len, exp_len);
    for (i = 0; i < rec_len && i < exp_len; i++) begin
      check_addr($sformatf("address of word %0d", i), rec_addr[i], exp_addr[i]);
      check_word($sformatf("data of word %0d", i), rec_data[i], exp_data[i]);
    end
  endtask

  task automatic wait_msg_ready();
    int n;
    n = 0;
    @(posedge clk_i);
    while (msg_ready_o !== 1'b1 && n < WaitLimit) begin
      @(posedge clk_i);
      n++;
    end
    if (msg_ready_o !== 1'b1) begin
      err_timeout++;
      $display("timeout: a message word was not accepted within %0d cycles", WaitLimit);
    end
  endtask

  task automatic wait_absorbed();
    int n;
    n = 0;
    @(posedge clk_i);
    while (absorbed_o !== 1'b1 && n < WaitLimit) begin
      @(posedge clk_i);
      n++;
    end
    if (absorbed_o !== 1'b1) begin
      err_timeout++;
      $display("timeout: absorbed_o did not pulse within %0d cycles", WaitLimit);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // called on a rising edge, returns on the edge of the last transfer
  task automatic send_message(int nfull, int nbytes);
    int i;
    for (i = 0; i < nfull; i++) begin
      msg_valid_i <= 1'b1;
      msg_data_i  <= msg_words[i];
      msg_strb_i  <= 8'hff;
      wait_msg_ready();
    end
    if (nbytes > 0) begin
      msg_valid_i <= 1'b1;
      msg_data_i  <= msg_words[nfull];
      msg_strb_i  <= msg_strb_t'((1 << nbytes) - 1);
      wait_msg_ready();
    end
    msg_valid_i <= 1'b0;
    msg_strb_i  <= 8'hff;
  endtask

  // one whole hash: start, message, process, wait for absorbed, done
  task automatic run_case(sha3_mode_e m, keccak_strength_e s, int nfull, int nbytes);
    @(posedge clk_i);
    mode_i     <= m;
    strength_i <= s;
    rec_len        = 0;
    run_count      = 0;
    absorbed_count = 0;
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    send_message(nfull, nbytes);
    process_i <= 1'b1;
    @(posedge clk_i);
    process_i <= 1'b0;
    wait_absorbed();
    @(posedge clk_i);
    done_i <= 1'b1;
    @(posedge clk_i);
    done_i <= 1'b0;
    @(posedge clk_i);
    build_expected(m, s, nfull, nbytes);
    compare_stream();
    check_count("run pulses", run_count, exp_len / rate_words(s));
    check_count("absorbed pulses", absorbed_count, 1);
  endtask

  task automatic test_reset_state();
    @(posedge clk_i);
    check_count("msg_ready_o after reset", (msg_ready_o === 1'b0) ? 0 : 1, 0);
    check_count("keccak_valid_o after reset", (keccak_valid_o === 1'b0) ? 0 : 1, 0);
    check_count("keccak_run_o after reset", (keccak_run_o === 1'b0) ? 0 : 1, 0);
    check_count("absorbed_o after reset", (absorbed_o === 1'b0) ? 0 : 1, 0);
    check_addr("address after reset", keccak_addr_o, '0);
  endtask

  task automatic test_sha3_short();
    run_case(Sha3, L256, 3, 3);
  endtask

  // 25 words overflow the 21-word SHAKE128 block
  task automatic test_shake_long();
    run_case(Shake, L128, 25, 0);
    check_count("SHAKE128 run pulses", run_count, 2);
  endtask

  task automatic test_cshake();
    int i;
    run_case(CShake, L256, 5, 2);
    check_word("prefix word 0", rec_data[0], {ns_data_i[47:0], 8'h88, 8'h01});
    for (i = 0; i < rec_len; i++) begin
      saved_data[i] = rec_data[i];
      saved_addr[i] = rec_addr[i];
    end
    saved_len  = rec_len;
    saved_runs = run_count;
  endtask

  // pad word falls on address 8, the last word of a SHA3-512 block
  task automatic test_sha3_pad_last();
    run_case(Sha3, L512, 8, 5);
  endtask

  task automatic test_backpressure();
    int i;
    stall_en <= 1'b1;
    run_case(CShake, L256, 5, 2);
    stall_en <= 1'b0;
    check_count("stalled stream length", rec_len, saved_len);
    for (i = 0; i < rec_len && i < saved_len; i++) begin
      check_addr($sformatf("stalled address %0d", i), rec_addr[i], saved_addr[i]);
      check_word($sformatf("stalled data %0d", i), rec_data[i], saved_data[i]);
    end
    check_count("stalled run pulses", run_count, saved_runs);
  endtask

  initial begin
    int i;
    // message words and the N/S string come from the generator up front
    for (i = 0; i < 32; i++) begin
      rng = xorshift32(rng);
      msg_words[i][31:0] = rng;
      rng = xorshift32(rng);
      msg_words[i][63:32] = rng;
    end
    for (i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      ns_fill[32*i +: 32] = rng;
    end
    rst_ni      <= 1'b0;
    msg_valid_i <= 1'b0;
    msg_data_i  <= '0;
    msg_strb_i  <= 8'hff;
    ns_data_i   <= ns_fill[NsBytes*8-1:0];
    mode_i      <= Sha3;
    strength_i  <= L256;
    start_i     <= 1'b0;
    process_i   <= 1'b0;
    done_i      <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset_state();
    test_sha3_short();
    test_shake_long();
    test_cshake();
    test_sha3_pad_last();
    test_backpressure();

    $display("errors: %0d value, %0d protocol, %0d timeout", err_value, err_proto,
             err_timeout);
    if (err_value + err_proto + err_timeout == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
